// File: alu.sv
// arithmetic logic unit
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::aluop_t alu_op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  input  logic [4:0]            shamt,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);

  always_comb begin
    // unknown op gives zero
    result = '0;
    case (alu_op)
      // shifts act on port b, like the isa's rt operand
      cpu_types_pkg::ALU_SLL: result = port_b << shamt;
      cpu_types_pkg::ALU_SRL: result = port_b >> shamt;
      // no overflow detection, add and sub wrap
      cpu_types_pkg::ALU_ADD: result = port_a + port_b;
      cpu_types_pkg::ALU_SUB: result = port_a - port_b;
      // bitwise group
      cpu_types_pkg::ALU_AND: result = port_a & port_b;
      cpu_types_pkg::ALU_OR:  result = port_a | port_b;
      cpu_types_pkg::ALU_XOR: result = port_a ^ port_b;
      cpu_types_pkg::ALU_NOR: result = ~(port_a | port_b);
      // set less than, signed then unsigned
      cpu_types_pkg::ALU_SLT: begin
        result = {31'b0, $signed(port_a) < $signed(port_b)};
      end
      cpu_types_pkg::ALU_SLTU: begin
        result = {31'b0, port_a < port_b};
      end
      default: result = '0;
    endcase
  end

  // branch compare uses sub, so equal operands give zero
  assign zero = (result == '0);

endmodule

// File: control_unit.sv
// instruction decoder
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::word_t instr,
  input  logic                 zero,
  output cpu_types_pkg::ctrl_t ctrl
);

  cpu_types_pkg::opcode_t opcode;
  cpu_types_pkg::funct_t  funct;

  assign opcode = cpu_types_pkg::opcode_t'(instr[31:26]);
  assign funct  = cpu_types_pkg::funct_t'(instr[5:0]);

  always_comb begin
    // raw instruction fields
    ctrl.rs         = instr[25:21];
    ctrl.rt         = instr[20:16];
    ctrl.rd         = instr[15:11];
    ctrl.shamt      = instr[10:6];
    ctrl.imm16      = instr[15:0];
    ctrl.jmp_target = instr[25:0];
    // defaults, a nop that just falls through
    ctrl.alu_op   = cpu_types_pkg::ALU_ADD;
    ctrl.alu_src  = cpu_types_pkg::SEL_REG_DATA;
    ctrl.reg_dst  = cpu_types_pkg::SEL_RD;
    ctrl.wdat_src = cpu_types_pkg::SEL_RESULT;
    ctrl.pc_src   = cpu_types_pkg::PC_SEQ;
    ctrl.extend   = 1'b0;
    ctrl.reg_wr   = 1'b0;
    ctrl.dren     = 1'b0;
    ctrl.dwen     = 1'b0;
    ctrl.halt     = 1'b0;

    if (instr == cpu_types_pkg::HALT_WORD) begin
      ctrl.halt = 1'b1;
    end else begin
      case (opcode)
        cpu_types_pkg::RTYPE: begin
          ctrl.reg_wr = 1'b1;
          case (funct)
            cpu_types_pkg::SLL:  ctrl.alu_op = cpu_types_pkg::ALU_SLL;
            cpu_types_pkg::SRL:  ctrl.alu_op = cpu_types_pkg::ALU_SRL;
            // signed forms decode as unsigned, no traps
            cpu_types_pkg::ADD,
            cpu_types_pkg::ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
            cpu_types_pkg::SUB,
            cpu_types_pkg::SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
            cpu_types_pkg::AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
            cpu_types_pkg::OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
            cpu_types_pkg::XOR:  ctrl.alu_op = cpu_types_pkg::ALU_XOR;
            cpu_types_pkg::NOR:  ctrl.alu_op = cpu_types_pkg::ALU_NOR;
            cpu_types_pkg::SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
            cpu_types_pkg::SLTU: ctrl.alu_op = cpu_types_pkg::ALU_SLTU;
            cpu_types_pkg::JR: begin
              ctrl.reg_wr = 1'b0;
              ctrl.pc_src = cpu_types_pkg::PC_JR;
            end
            default: ctrl.reg_wr = 1'b0;
          endcase
        end
        // immediate arithmetic, sign extended
        cpu_types_pkg::ADDI,
        cpu_types_pkg::ADDIU,
        cpu_types_pkg::SLTI: begin
          ctrl.alu_op  = (opcode == cpu_types_pkg::SLTI) ? cpu_types_pkg::ALU_SLT
                                                         : cpu_types_pkg::ALU_ADD;
          ctrl.alu_src = cpu_types_pkg::SEL_IMM16;
          ctrl.extend  = 1'b1;
          ctrl.reg_dst = cpu_types_pkg::SEL_RT;
          ctrl.reg_wr  = 1'b1;
        end
        // logical immediates zero extend
        cpu_types_pkg::ANDI,
        cpu_types_pkg::ORI,
        cpu_types_pkg::XORI: begin
          if (opcode == cpu_types_pkg::ANDI) begin
            ctrl.alu_op = cpu_types_pkg::ALU_AND;
          end else if (opcode == cpu_types_pkg::ORI) begin
            ctrl.alu_op = cpu_types_pkg::ALU_OR;
          end else begin
            ctrl.alu_op = cpu_types_pkg::ALU_XOR;
          end
          ctrl.alu_src = cpu_types_pkg::SEL_IMM16;
          ctrl.reg_dst = cpu_types_pkg::SEL_RT;
          ctrl.reg_wr  = 1'b1;
        end
        cpu_types_pkg::LUI: begin
          ctrl.wdat_src = cpu_types_pkg::SEL_LUI;
          ctrl.reg_dst  = cpu_types_pkg::SEL_RT;
          ctrl.reg_wr   = 1'b1;
        end
        // address is rs plus signed offset
        cpu_types_pkg::LW,
        cpu_types_pkg::SW: begin
          ctrl.alu_src = cpu_types_pkg::SEL_IMM16;
          ctrl.extend  = 1'b1;
          ctrl.reg_dst = cpu_types_pkg::SEL_RT;
          if (opcode == cpu_types_pkg::LW) begin
            ctrl.wdat_src = cpu_types_pkg::SEL_DLOAD;
            ctrl.reg_wr   = 1'b1;
            ctrl.dren     = 1'b1;
          end else begin
            ctrl.dwen = 1'b1;
          end
        end
        // compare by subtraction, extender feeds the offset
        cpu_types_pkg::BEQ,
        cpu_types_pkg::BNE: begin
          ctrl.alu_op = cpu_types_pkg::ALU_SUB;
          ctrl.extend = 1'b1;
          if (zero == (opcode == cpu_types_pkg::BEQ)) begin
            ctrl.pc_src = cpu_types_pkg::PC_BRANCH;
          end
        end
        cpu_types_pkg::J: ctrl.pc_src = cpu_types_pkg::PC_JUMP;
        // link goes to r31
        cpu_types_pkg::JAL: begin
          ctrl.pc_src   = cpu_types_pkg::PC_JUMP;
          ctrl.reg_dst  = cpu_types_pkg::SEL_R31;
          ctrl.wdat_src = cpu_types_pkg::SEL_NPC;
          ctrl.reg_wr   = 1'b1;
        end
        default: ctrl.reg_wr = 1'b0;
      endcase
    end
  end

endmodule

// File: cpu_types_pkg.sv
// mips core shared types
package cpu_types_pkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // halt is the all-ones instruction word
  localparam word_t HALT_WORD = 32'hffff_ffff;

  // primary opcodes kept
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDI  = 6'h08,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcode_t;

  // r-type function codes
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  // next pc source
  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JR} pc_src_t;

  // alu port b source
  typedef enum logic {SEL_REG_DATA, SEL_IMM16} alu_src_t;

  // write register select, r31 only for jal
  typedef enum logic [1:0] {SEL_RD, SEL_RT, SEL_R31} reg_dst_t;

  // write data source
  typedef enum logic [1:0] {SEL_RESULT, SEL_NPC, SEL_DLOAD, SEL_LUI} wdat_src_t;

  // everything the decoder hands to the datapath
  typedef struct packed {
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic [25:0] jmp_target;
    aluop_t      alu_op;
    alu_src_t    alu_src;
    reg_dst_t    reg_dst;
    wdat_src_t   wdat_src;
    pc_src_t     pc_src;
    logic        extend;
    logic        reg_wr;
    logic        dren;
    logic        dwen;
    logic        halt;
  } ctrl_t;

  // core to memory
  typedef struct packed {
    logic  imem_ren;
    word_t imem_addr;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  halt;
  } dp_req_t;

  // memory to core
  typedef struct packed {
    logic  ihit;
    word_t imem_load;
    logic  dhit;
    word_t dmem_load;
  } mem_rsp_t;

endpackage

// File: datapath.f
cpu_types_pkg.sv
alu.sv
control_unit.sv
register_file.sv
pc.sv
request_unit.sv
datapath.sv
datapath_checker.sv
tb_datapath.sv

// File: datapath.sv
// single cycle mips datapath
`timescale 1ns/1ps

module datapath #(
  parameter cpu_types_pkg::word_t pc_init = 32'h0
) (
  input  logic                    CLK,
  input  logic                    rst,
  output cpu_types_pkg::dp_req_t  req,
  input  cpu_types_pkg::mem_rsp_t rsp
);

  cpu_types_pkg::ctrl_t    ctrl;
  cpu_types_pkg::word_t    instr;
  cpu_types_pkg::word_t    instr_q;
  cpu_types_pkg::word_t    result;
  cpu_types_pkg::word_t    rdat1;
  cpu_types_pkg::word_t    rdat2;
  cpu_types_pkg::word_t    imm_ext;
  cpu_types_pkg::word_t    port_b;
  cpu_types_pkg::word_t    wdat;
  cpu_types_pkg::word_t    pc_addr;
  cpu_types_pkg::regbits_t wsel;
  logic                    zero;
  logic                    mem_op;
  logic                    pc_adv;
  logic                    reg_wen;
  logic                    dmem_ren;
  logic                    dmem_wen;
  logic                    imem_ren;
  logic                    halt_out;

  // instruction seen on ihit, held through a pending data access
  always_ff @(posedge CLK) begin
    if (rst) begin
      instr_q <= '0;
    end else if (rsp.ihit) begin
      instr_q <= rsp.imem_load;
    end
  end

  assign instr = rsp.ihit ? rsp.imem_load : instr_q;

  control_unit u_control (
    .instr(instr),
    .zero (zero),
    .ctrl (ctrl)
  );

  // loads and stores retire on dhit, everything else on ihit
  assign mem_op  = ctrl.dren | ctrl.dwen;
  assign pc_adv  = (rsp.ihit & ~mem_op) | (rsp.dhit & mem_op);
  assign reg_wen = ctrl.reg_wr & ((rsp.ihit & ~ctrl.dren) | (rsp.dhit & ctrl.dren));

  pc #(
    .pc_init(pc_init)
  ) u_pc (
    .CLK       (CLK),
    .rst       (rst),
    .ihit      (pc_adv),
    .pc_src    (ctrl.pc_src),
    .br_offset (imm_ext),
    .jmp_target(ctrl.jmp_target),
    .jr_addr   (rdat1),
    .pc_addr   (pc_addr)
  );

  // write register select, jal links into r31
  always_comb begin
    case (ctrl.reg_dst)
      cpu_types_pkg::SEL_RT:  wsel = ctrl.rt;
      cpu_types_pkg::SEL_R31: wsel = 5'd31;
      default:                wsel = ctrl.rd;
    endcase
  end

  // write data select
  always_comb begin
    case (ctrl.wdat_src)
      cpu_types_pkg::SEL_NPC:   wdat = pc_addr + 32'd4;
      cpu_types_pkg::SEL_DLOAD: wdat = rsp.dmem_load;
      cpu_types_pkg::SEL_LUI:   wdat = {ctrl.imm16, 16'h0};
      default:                  wdat = result;
    endcase
  end

  register_file u_regs (
    .CLK  (CLK),
    .rst  (rst),
    .wen  (reg_wen),
    .wsel (wsel),
    .wdat (wdat),
    .rsel1(ctrl.rs),
    .rsel2(ctrl.rt),
    .rdat1(rdat1),
    .rdat2(rdat2)
  );

  // sign or zero extension of imm16
  assign imm_ext = ctrl.extend ? {{16{ctrl.imm16[15]}}, ctrl.imm16} : {16'h0, ctrl.imm16};

  // alu port b
  assign port_b = (ctrl.alu_src == cpu_types_pkg::SEL_IMM16) ? imm_ext : rdat2;

  alu u_alu (
    .alu_op(ctrl.alu_op),
    .port_a(rdat1),
    .port_b(port_b),
    .shamt (ctrl.shamt),
    .result(result),
    .zero  (zero)
  );

  request_unit u_request (
    .CLK     (CLK),
    .rst     (rst),
    .ihit    (rsp.ihit),
    .dhit    (rsp.dhit),
    .dren    (ctrl.dren),
    .dwen    (ctrl.dwen),
    .halt    (ctrl.halt),
    .dmem_ren(dmem_ren),
    .dmem_wen(dmem_wen),
    .imem_ren(imem_ren),
    .halt_out(halt_out)
  );

  // request out to memory
  assign req.imem_ren   = imem_ren;
  assign req.imem_addr  = pc_addr;
  assign req.dmem_ren   = dmem_ren;
  assign req.dmem_wen   = dmem_wen;
  // address from alu, store data straight from rt
  assign req.dmem_addr  = result;
  assign req.dmem_store = rdat2;
  assign req.halt       = halt_out;

endmodule

// File: datapath_checker.sv
// datapath store and halt checker
`timescale 1ns/1ps

module datapath_checker (
  input  logic                    CLK,
  input  logic                    rst,
  input  cpu_types_pkg::dp_req_t  req,
  input  cpu_types_pkg::mem_rsp_t rsp,
  input  int                      row,
  input  cpu_types_pkg::word_t    exp_addr,
  input  cpu_types_pkg::word_t    exp_data,
  input  logic                    test_done,
  output int                      error_count,
  output int                      failed_tests
);

  int stores;
  int errors_before;

  initial begin
    error_count   = 0;
    failed_tests  = 0;
    stores        = 0;
    errors_before = 0;
  end

  // rsp changes just after the rising edge, so mid-cycle is quiet
  always @(negedge CLK) begin
    if (rst) begin
      stores = 0;
    end else begin
      // a store completes when dhit meets dmem_wen
      if (req.dmem_wen && rsp.dhit) begin
        stores++;
        if (stores > 1) begin
          $display("test %0d wrote memory more than once", row);
          error_count++;
        end
        if (req.dmem_addr !== exp_addr) begin
          $display("Fail at %0d ns: dmem_addr got %h expected %h",
                   $time, req.dmem_addr, exp_addr);
          error_count++;
        end
        if (req.dmem_store !== exp_data) begin
          $display("Fail at %0d ns: dmem_store got %h expected %h",
                   $time, req.dmem_store, exp_data);
          error_count++;
        end
      end
      // halted core keeps every enable low
      if (req.halt && (req.imem_ren || req.dmem_ren || req.dmem_wen)) begin
        $display("test %0d issued a memory request after halt at %0d ns", row, $time);
        error_count++;
      end
      if (test_done) begin
        if (stores == 0) begin
          $display("test %0d halted without storing its result", row);
          error_count++;
        end
        if (error_count == errors_before) begin
          $display("test %0d passed", row);
        end else begin
          $display("test %0d failed", row);
          failed_tests++;
        end
        errors_before = error_count;
      end
    end
  end

endmodule

// File: pc.sv
// program counter
`timescale 1ns/1ps

module pc #(
  parameter cpu_types_pkg::word_t pc_init = 32'h0
) (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   ihit,
  input  cpu_types_pkg::pc_src_t pc_src,
  input  cpu_types_pkg::word_t   br_offset,
  input  logic [25:0]            jmp_target,
  input  cpu_types_pkg::word_t   jr_addr,
  output cpu_types_pkg::word_t   pc_addr
);

  cpu_types_pkg::word_t npc;
  cpu_types_pkg::word_t next_pc;

  assign npc = pc_addr + 32'd4;

  always_comb begin
    case (pc_src)
      // offset counts words, relative to the delay-free npc
      cpu_types_pkg::PC_BRANCH: next_pc = npc + (br_offset << 2);
      // keep the region bits of npc
      cpu_types_pkg::PC_JUMP:   next_pc = {npc[31:28], jmp_target, 2'b00};
      cpu_types_pkg::PC_JR:     next_pc = jr_addr;
      default:                  next_pc = npc;
    endcase
  end

  // advance only when the current instruction completes
  always_ff @(posedge CLK) begin
    if (rst) begin
      pc_addr <= pc_init;
    end else if (ihit) begin
      pc_addr <= next_pc;
    end
  end

endmodule

// File: register_file.sv
// register file
`timescale 1ns/1ps

module register_file (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    // r0 never written, so it reads zero after reset
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;
    end
  end

  // combinational read ports
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

// File: request_unit.sv
// memory request unit
`timescale 1ns/1ps

module request_unit (
  input  logic CLK,
  input  logic rst,
  input  logic ihit,
  input  logic dhit,
  input  logic dren,
  input  logic dwen,
  input  logic halt,
  output logic dmem_ren,
  output logic dmem_wen,
  output logic imem_ren,
  output logic halt_out
);

  always_ff @(posedge CLK) begin
    if (rst) begin
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
      halt_out <= 1'b0;
    end else begin
      // data request ends on its hit
      if (dhit) begin
        dmem_ren <= 1'b0;
        dmem_wen <= 1'b0;
      // decoder intent only counts on a fetched instruction
      end else if (ihit) begin
        dmem_ren <= dren;
        dmem_wen <= dwen;
      end
      // sticky until reset
      if (ihit && halt) begin
        halt_out <= 1'b1;
      end
    end
  end

  // fetch runs until halt
  assign imem_ren = ~halt_out;

endmodule

// File: tb_datapath.sv
// datapath testbench
`timescale 1ns/1ps

module tb_datapath;

  localparam int NUM_ROWS = 24;
  localparam int TIMEOUT  = 400;
  localparam int QUIET    = 8;
  // operation under test sits after four setup words
  localparam cpu_types_pkg::word_t OP_ADDR = 32'd16;

  typedef enum logic [4:0] {
    T_ADDU, T_SUBU, T_AND, T_OR, T_XOR, T_NOR, T_SLT, T_SLTU, T_SLL, T_SRL,
    T_ADDIU, T_SLTI, T_ANDI, T_ORI, T_XORI, T_LUI, T_LW, T_BEQ, T_BNE,
    T_JAL, T_JR, T_R0
  } test_op_t;

  typedef struct packed {
    test_op_t             op;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t b;
    cpu_types_pkg::word_t exp;
  } row_t;

  logic                    CLK;
  logic                    rst;
  logic                    test_done;
  logic                    timed_out;
  cpu_types_pkg::dp_req_t  req;
  cpu_types_pkg::mem_rsp_t rsp;
  cpu_types_pkg::word_t    mem [256];
  cpu_types_pkg::word_t    exp_addr;
  cpu_types_pkg::word_t    exp_data;
  row_t                    rows [NUM_ROWS];
  logic [31:0]             lfsr_state;
  int                      cur_row;
  int                      error_count;
  int                      failed_tests;

  datapath #(
    .pc_init(32'h0)
  ) u_dut (
    .CLK(CLK),
    .rst(rst),
    .req(req),
    .rsp(rsp)
  );

  datapath_checker u_check (
    .CLK         (CLK),
    .rst         (rst),
    .req         (req),
    .rsp         (rsp),
    .row         (cur_row),
    .exp_addr    (exp_addr),
    .exp_data    (exp_data),
    .test_done   (test_done),
    .error_count (error_count),
    .failed_tests(failed_tests)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // two lfsr bits give 0 to 3 wait cycles
  task automatic draw_wait(output int w);
    w = 0;
    for (int k = 0; k < 2; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = (w << 1) | int'(lfsr_state[0]);
    end
  endtask

  // instruction encoders
  function automatic cpu_types_pkg::word_t r_type(input logic [4:0] rs, input logic [4:0] rt,
                                                  input logic [4:0] rd, input logic [4:0] sh,
                                                  input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpu_types_pkg::word_t i_type(input logic [5:0] op, input logic [4:0] rs,
                                                  input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_types_pkg::word_t j_type(input logic [5:0] op,
                                                  input cpu_types_pkg::word_t addr);
    return {op, addr[27:2]};
  endfunction

  // single word for the plain alu and immediate rows with the result in r3
  function automatic cpu_types_pkg::word_t op_word(input test_op_t op,
                                                   input cpu_types_pkg::word_t b);
    case (op)
      T_ADDU:  return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::ADDU);
      T_SUBU:  return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::SUBU);
      T_AND:   return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::AND);
      T_OR:    return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::OR);
      T_XOR:   return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::XOR);
      T_NOR:   return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::NOR);
      T_SLT:   return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::SLT);
      T_SLTU:  return r_type(5'd1, 5'd2, 5'd3, 5'd0, cpu_types_pkg::SLTU);
      // shifts take rt and the shamt field
      T_SLL:   return r_type(5'd0, 5'd1, 5'd3, b[4:0], cpu_types_pkg::SLL);
      T_SRL:   return r_type(5'd0, 5'd1, 5'd3, b[4:0], cpu_types_pkg::SRL);
      T_ADDIU: return i_type(cpu_types_pkg::ADDIU, 5'd1, 5'd3, b[15:0]);
      T_SLTI:  return i_type(cpu_types_pkg::SLTI, 5'd1, 5'd3, b[15:0]);
      T_ANDI:  return i_type(cpu_types_pkg::ANDI, 5'd1, 5'd3, b[15:0]);
      T_ORI:   return i_type(cpu_types_pkg::ORI, 5'd1, 5'd3, b[15:0]);
      T_XORI:  return i_type(cpu_types_pkg::XORI, 5'd1, 5'd3, b[15:0]);
      T_LUI:   return i_type(cpu_types_pkg::LUI, 5'd0, 5'd3, b[15:0]);
      default: return cpu_types_pkg::HALT_WORD;
    endcase
  endfunction

  // expected stored value from the instruction set rules
  function automatic cpu_types_pkg::word_t isa_result(input row_t r);
    cpu_types_pkg::word_t sext;
    cpu_types_pkg::word_t zext;
    sext = {{16{r.b[15]}}, r.b[15:0]};
    zext = {16'h0, r.b[15:0]};
    case (r.op)
      T_ADDU:  return r.a + r.b;
      T_SUBU:  return r.a - r.b;
      T_AND:   return r.a & r.b;
      T_OR:    return r.a | r.b;
      T_XOR:   return r.a ^ r.b;
      T_NOR:   return ~(r.a | r.b);
      T_SLT:   return {31'b0, $signed(r.a) < $signed(r.b)};
      T_SLTU:  return {31'b0, r.a < r.b};
      T_SLL:   return r.a << r.b[4:0];
      T_SRL:   return r.a >> r.b[4:0];
      T_ADDIU: return r.a + sext;
      T_SLTI:  return {31'b0, $signed(r.a) < $signed(sext)};
      T_ANDI:  return r.a & zext;
      T_ORI:   return r.a | zext;
      T_XORI:  return r.a ^ zext;
      T_LUI:   return {r.b[15:0], 16'h0};
      T_LW:    return r.b;
      // taken path marks 2222 and fall through marks 1111
      T_BEQ:   return (r.a == r.b) ? 32'h2222 : 32'h1111;
      T_BNE:   return (r.a != r.b) ? 32'h2222 : 32'h1111;
      T_JAL:   return OP_ADDR + 32'd4;
      T_JR:    return zext;
      default: return 32'h0;
    endcase
  endfunction

  task automatic emit(inout int p, input cpu_types_pkg::word_t w);
    mem[p] = w;
    p++;
  endtask

  task automatic fill_memory();
    for (int n = 0; n < 256; n++) begin
      // low bits carry the byte address
      mem[n] = 32'hbeef_0000 | (n << 2);
    end
  endtask

  task automatic build_program(input int idx);
    row_t       r;
    int         p;
    logic [4:0] src;
    r = rows[idx];
    p = 0;
    src = (r.op == T_R0) ? 5'd0 : 5'd3;
    // a into r1, b into r2
    emit(p, i_type(cpu_types_pkg::LUI, 5'd0, 5'd1, r.a[31:16]));
    emit(p, i_type(cpu_types_pkg::ORI, 5'd1, 5'd1, r.a[15:0]));
    emit(p, i_type(cpu_types_pkg::LUI, 5'd0, 5'd2, r.b[31:16]));
    emit(p, i_type(cpu_types_pkg::ORI, 5'd2, 5'd2, r.b[15:0]));
    case (r.op)
      T_LW: begin
        mem[r.a[9:2]] = r.b;
        emit(p, i_type(cpu_types_pkg::LW, 5'd1, 5'd3, 16'h0));
      end
      T_BEQ, T_BNE: begin
        emit(p, i_type((r.op == T_BEQ) ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE,
                       5'd1, 5'd2, 16'd2));
        emit(p, i_type(cpu_types_pkg::ORI, 5'd0, 5'd3, 16'h1111));
        emit(p, j_type(cpu_types_pkg::J, OP_ADDR + 32'd16));
        emit(p, i_type(cpu_types_pkg::ORI, 5'd0, 5'd3, 16'h2222));
      end
      T_JAL: begin
        emit(p, j_type(cpu_types_pkg::JAL, OP_ADDR + 32'd8));
        // clobbers the link if the jump falls through
        emit(p, i_type(cpu_types_pkg::ORI, 5'd0, 5'd31, 16'hdead));
        emit(p, r_type(5'd31, 5'd0, 5'd3, 5'd0, cpu_types_pkg::OR));
      end
      T_JR: begin
        // call a one-word routine that returns through r31
        emit(p, j_type(cpu_types_pkg::JAL, OP_ADDR + 32'd12));
        emit(p, i_type(cpu_types_pkg::ORI, 5'd0, 5'd3, r.b[15:0]));
        emit(p, j_type(cpu_types_pkg::J, OP_ADDR + 32'd16));
        emit(p, r_type(5'd31, 5'd0, 5'd0, 5'd0, cpu_types_pkg::JR));
      end
      T_R0:    emit(p, r_type(5'd1, 5'd2, 5'd0, 5'd0, cpu_types_pkg::ADDU));
      default: emit(p, op_word(r.op, r.b));
    endcase
    emit(p, i_type(cpu_types_pkg::SW, 5'd0, src, 16'(256 + 4 * idx)));
    emit(p, cpu_types_pkg::HALT_WORD);
  endtask

  // memory model serves one access at a time and data before fetch
  initial begin
    cpu_types_pkg::dp_req_t cur;
    int                     wait_left;
    logic                   busy;
    rsp = '0;
    lfsr_state = 32'h0ec1_275f;
    wait_left = 0;
    busy = 1'b0;
    forever begin
      @(posedge CLK);
      #1;
      // req settled at the edge and is read before rsp changes
      cur = req;
      rsp.ihit = 1'b0;
      rsp.dhit = 1'b0;
      if (cur.dmem_ren || cur.dmem_wen || cur.imem_ren) begin
        if (!busy) begin
          draw_wait(wait_left);
          busy = 1'b1;
        end
        if (wait_left > 0) begin
          wait_left--;
        end else if (cur.dmem_ren || cur.dmem_wen) begin
          busy = 1'b0;
          rsp.dhit = 1'b1;
          rsp.dmem_load = mem[cur.dmem_addr[9:2]];
          if (cur.dmem_wen) begin
            mem[cur.dmem_addr[9:2]] = cur.dmem_store;
          end
        end else begin
          busy = 1'b0;
          rsp.ihit = 1'b1;
          rsp.imem_load = mem[cur.imem_addr[9:2]];
        end
      end
    end
  end

  initial begin
    int cycles;
    rst = 1'b1;
    test_done = 1'b0;
    timed_out = 1'b0;
    cur_row = 0;
    exp_addr = '0;
    exp_data = '0;
    rows[0]  = '{T_ADDU,  32'h7fff_ffff, 32'h0000_0001, 32'h0};
    rows[1]  = '{T_SUBU,  32'h0000_0000, 32'h0000_0001, 32'h0};
    rows[2]  = '{T_AND,   32'hf0f0_1234, 32'hff00_ff00, 32'h0};
    rows[3]  = '{T_OR,    32'h8000_0000, 32'h0000_0001, 32'h0};
    rows[4]  = '{T_XOR,   32'ha5a5_a5a5, 32'hffff_0000, 32'h0};
    rows[5]  = '{T_NOR,   32'h0000_0000, 32'h0000_0000, 32'h0};
    rows[6]  = '{T_SLT,   32'h8000_0000, 32'h7fff_ffff, 32'h0};
    rows[7]  = '{T_SLTU,  32'h8000_0000, 32'h7fff_ffff, 32'h0};
    rows[8]  = '{T_SLL,   32'h8000_0001, 32'h0000_0004, 32'h0};
    rows[9]  = '{T_SRL,   32'h8000_0000, 32'h0000_001f, 32'h0};
    rows[10] = '{T_ADDIU, 32'h0000_0010, 32'h0000_fff0, 32'h0};
    rows[11] = '{T_SLTI,  32'h0000_0000, 32'h0000_8000, 32'h0};
    rows[12] = '{T_ANDI,  32'hffff_ffff, 32'h0000_8001, 32'h0};
    rows[13] = '{T_ORI,   32'h1234_0000, 32'h0000_ffff, 32'h0};
    rows[14] = '{T_XORI,  32'hffff_ffff, 32'h0000_ffff, 32'h0};
    rows[15] = '{T_LUI,   32'h0000_0000, 32'h0000_abcd, 32'h0};
    rows[16] = '{T_LW,    32'h0000_0300, 32'hcafe_f00d, 32'h0};
    rows[17] = '{T_BEQ,   32'h0000_0005, 32'h0000_0005, 32'h0};
    rows[18] = '{T_BEQ,   32'h0000_0005, 32'h0000_0006, 32'h0};
    rows[19] = '{T_BNE,   32'h0000_0005, 32'h0000_0006, 32'h0};
    rows[20] = '{T_BNE,   32'h0000_0007, 32'h0000_0007, 32'h0};
    rows[21] = '{T_JAL,   32'h0000_0000, 32'h0000_0000, 32'h0};
    rows[22] = '{T_JR,    32'h0000_0000, 32'h0000_4321, 32'h0};
    rows[23] = '{T_R0,    32'h1234_5678, 32'h1111_1111, 32'h0};
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      // core is halted or not yet started here
      fill_memory();
      rows[i].exp = isa_result(rows[i]);
      build_program(i);
      cur_row = i;
      exp_addr = 32'd256 + 32'(4 * i);
      exp_data = rows[i].exp;
      rst = 1'b1;
      repeat (5) @(posedge CLK);
      #1;
      rst = 1'b0;
      cycles = 0;
      while (!req.halt && cycles < TIMEOUT) begin
        @(posedge CLK);
        #1;
        cycles++;
      end
      if (!req.halt) begin
        $display("test %0d did not reach halt within %0d cycles", i, TIMEOUT);
        timed_out = 1'b1;
      end else begin
        // the checker watches for stray requests meanwhile
        repeat (QUIET) @(posedge CLK);
        #1;
        test_done = 1'b1;
        @(posedge CLK);
        #1;
        test_done = 1'b0;
      end
    end
    $display("%0d tests, %0d failed, %0d errors", NUM_ROWS, failed_tests, error_count);
    if (!timed_out && error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
